// File: include/tensor_settings.svh
`ifndef TENSOR_SETTINGS_SVH
`define TENSOR_SETTINGS_SVH

// warp shape, one octet per 8 lanes
`define TC_NUM_OCTETS 2
`define TC_NUM_LANES (8 * `TC_NUM_OCTETS)

// register word width
`define TC_XLEN 32

// instruction metadata fields
`define TC_UUID_W 8
`define TC_WID_W 2
`define TC_RD_W 5

// number of DPU stages from tile to result, at least 2
`define TC_DPU_LATENCY 2

// pending metadata entries, two per instruction in flight
`define TC_META_DEPTH 16

`endif

// File: verilog/tensor_pkg.sv
`include "tensor_settings.svh"

package tensor_pkg;

    // metadata carried from dispatch to commit
    typedef struct packed {
        logic [`TC_UUID_W-1:0] uuid;
        logic [`TC_WID_W-1:0]  wid;
        logic [`TC_RD_W-1:0]   rd;
        logic                  wb;
    } tc_meta_t;

    // one dispatch beat
    // step[0] picks the A column pair, step[1] picks the B row half
    typedef struct packed {
        tc_meta_t                                 meta;
        logic [1:0]                               step;
        logic [`TC_NUM_LANES-1:0][`TC_XLEN-1:0]   rs1;
        logic [`TC_NUM_LANES-1:0][`TC_XLEN-1:0]   rs2;
        logic [`TC_NUM_LANES-1:0][`TC_XLEN-1:0]   rs3;
    } tc_operand_t;

    // operands of one octet, indexed [row][col]
    typedef struct packed {
        logic [3:0][1:0][`TC_XLEN-1:0] a;
        logic [1:0][3:0][`TC_XLEN-1:0] b;
        logic [3:0][3:0][`TC_XLEN-1:0] c;
    } tc_tile_t;

    // one commit beat, last marks the second beat of a pair
    typedef struct packed {
        tc_meta_t                               meta;
        logic [`TC_NUM_LANES-1:0][`TC_XLEN-1:0] data;
        logic                                   last;
    } tc_commit_t;

endpackage

// File: verilog/tensor_operand_stage.sv
`timescale 1ns/1ps
`include "tensor_settings.svh"

module tensor_operand_stage (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     operand_valid,
    output logic                                     operand_ready,
    input  tensor_pkg::tc_operand_t                  operand,
    input  logic                                     stall,
    output logic                                     tile_valid,
    output tensor_pkg::tc_tile_t [`TC_NUM_OCTETS-1:0] tiles,
    output logic                                     meta_push,
    output tensor_pkg::tc_meta_t                     meta
);

    // lane offset of the high lane group of every octet
    localparam int GRP = 4 * `TC_NUM_OCTETS;

    logic fire;
    // low on the first beat of a pair, high on the second
    logic substep;

    // halves selected from the beat on the bus
    logic [`TC_NUM_OCTETS-1:0][3:0][`TC_XLEN-1:0] a_live;
    logic [`TC_NUM_OCTETS-1:0][3:0][`TC_XLEN-1:0] b_live;
    logic [`TC_NUM_OCTETS-1:0][7:0][`TC_XLEN-1:0] c_live;

    // halves captured from the first beat
    logic [`TC_NUM_OCTETS-1:0][3:0][`TC_XLEN-1:0] a_buf;
    logic [`TC_NUM_OCTETS-1:0][3:0][`TC_XLEN-1:0] b_buf;
    logic [`TC_NUM_OCTETS-1:0][7:0][`TC_XLEN-1:0] c_buf;

    assign operand_ready = ~stall;
    assign fire = operand_valid && operand_ready;
    assign tile_valid = fire && substep;

    // every beat leaves one metadata entry for its commit beat
    assign meta_push = fire;
    assign meta = operand.meta;

    always_ff @(posedge clk) begin
        if (reset) begin
            substep <= 1'b0;
        end else if (fire) begin
            substep <= ~substep;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !substep) begin
            a_buf <= a_live;
            b_buf <= b_live;
            c_buf <= c_live;
        end
    end

    // element e0..e3 is the low group, e4..e7 the high group
    always_comb begin
        for (int o = 0; o < `TC_NUM_OCTETS; o++) begin
            for (int e = 0; e < 4; e++) begin
                c_live[o][e]     = operand.rs3[4*o + e];
                c_live[o][e + 4] = operand.rs3[GRP + 4*o + e];
                // B row half comes from one whole group
                b_live[o][e] = operand.step[1] ? operand.rs2[GRP + 4*o + e]
                                               : operand.rs2[4*o + e];
            end
            // A rows 0,1 from the low group and rows 2,3 from the high group
            for (int r = 0; r < 2; r++) begin
                a_live[o][r]     = operand.rs1[4*o + 2*operand.step[0] + r];
                a_live[o][r + 2] = operand.rs1[GRP + 4*o + 2*operand.step[0] + r];
            end
        end
    end

    // first beat supplies k=0 and the even C columns
    always_comb begin
        for (int o = 0; o < `TC_NUM_OCTETS; o++) begin
            for (int r = 0; r < 4; r++) begin
                tiles[o].a[r][0] = a_buf[o][r];
                tiles[o].a[r][1] = a_live[o][r];
            end
            tiles[o].b[0] = b_buf[o];
            tiles[o].b[1] = b_live[o];
            // rows pair the C elements (0,2) (1,3) (4,6) (5,7)
            for (int r = 0; r < 4; r++) begin
                tiles[o].c[r][0] = c_buf[o][(r/2)*4 + r%2];
                tiles[o].c[r][1] = c_live[o][(r/2)*4 + r%2];
                tiles[o].c[r][2] = c_buf[o][(r/2)*4 + r%2 + 2];
                tiles[o].c[r][3] = c_live[o][(r/2)*4 + r%2 + 2];
            end
        end
    end

endmodule

// File: verilog/tensor_dpu.sv
`timescale 1ns/1ps
`include "tensor_settings.svh"

module tensor_dpu (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 stall,
    input  logic                                                 tile_valid,
    input  tensor_pkg::tc_tile_t [`TC_NUM_OCTETS-1:0]             tiles,
    output logic                                                 result_valid,
    output logic [`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0]    result
);

    localparam int LAT = `TC_DPU_LATENCY;

    // stage 1: both partial products of every output element, plus C
    logic [`TC_NUM_OCTETS-1:0][3:0][3:0][1:0][`TC_XLEN-1:0] prod_q;
    logic [`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0]      acc_q;
    logic                                                   prod_valid;

    // stage 2 onward: finished sums moving towards the output
    logic [`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0]      sum_d;
    logic [LAT-2:0][`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0] sum_q;
    logic [LAT-2:0]                                         sum_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
            sum_valid  <= '0;
        end else if (!stall) begin
            prod_valid   <= tile_valid;
            sum_valid[0] <= prod_valid;
            for (int j = 1; j < LAT - 1; j++) begin
                sum_valid[j] <= sum_valid[j-1];
            end
        end
    end

    // products wrap to the word width
    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int o = 0; o < `TC_NUM_OCTETS; o++) begin
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        for (int k = 0; k < 2; k++) begin
                            prod_q[o][r][c][k] <= tiles[o].a[r][k] * tiles[o].b[k][c];
                        end
                    end
                end
                acc_q[o] <= tiles[o].c;
            end
        end
    end

    always_comb begin
        for (int o = 0; o < `TC_NUM_OCTETS; o++) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    sum_d[o][r][c] = prod_q[o][r][c][0] + prod_q[o][r][c][1] + acc_q[o][r][c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            sum_q[0] <= sum_d;
            for (int j = 1; j < LAT - 1; j++) begin
                sum_q[j] <= sum_q[j-1];
            end
        end
    end

    assign result_valid = sum_valid[LAT-2];
    assign result = sum_q[LAT-2];

endmodule

// File: verilog/tensor_writeback.sv
`timescale 1ns/1ps
`include "tensor_settings.svh"

module tensor_writeback (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              result_valid,
    input  logic [`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0] result,
    output logic                                              stall,
    input  logic                                              meta_push,
    input  tensor_pkg::tc_meta_t                              meta,
    output logic                                              commit_valid,
    input  logic                                              commit_ready,
    output tensor_pkg::tc_commit_t                            commit
);
    import tensor_pkg::*;

    localparam int GRP   = 4 * `TC_NUM_OCTETS;
    localparam int DEPTH = `TC_META_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // staged result tile and its beat state
    logic [`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0] tile_q;
    logic full;
    logic half;

    logic commit_fire;
    logic free;
    logic load;

    // metadata of dispatched beats waiting for their commit
    tc_meta_t         meta_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    assign commit_valid = full;
    assign commit_fire = commit_valid && commit_ready;
    // the tile is released by the second beat
    assign free = commit_fire && half;
    assign stall = full && !free;
    assign load = result_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
            half <= 1'b0;
        end else begin
            if (load) begin
                full <= 1'b1;
            end else if (free) begin
                full <= 1'b0;
            end
            if (commit_fire) begin
                half <= ~half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tile_q <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (meta_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (commit_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (meta_push) begin
            meta_mem[wr_ptr] <= meta;
        end
    end

    // first beat takes the even D columns, second beat the odd ones
    always_comb begin
        commit.meta = meta_mem[rd_ptr];
        commit.last = half;
        for (int o = 0; o < `TC_NUM_OCTETS; o++) begin
            for (int j = 0; j < 4; j++) begin
                // low group carries rows 0,1
                commit.data[4*o + j] = tile_q[o][j%2][2*(j/2) + half];
                // high group carries rows 2,3
                commit.data[GRP + 4*o + j] = tile_q[o][2 + j%2][2*(j/2) + half];
            end
        end
    end

endmodule

// File: verilog/tensor_core.sv
`timescale 1ns/1ps
`include "tensor_settings.svh"

module tensor_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   operand_valid,
    output logic                   operand_ready,
    input  tensor_pkg::tc_operand_t operand,
    output logic                   commit_valid,
    input  logic                   commit_ready,
    output tensor_pkg::tc_commit_t  commit
);
    import tensor_pkg::*;

    logic                                              tile_valid;
    tc_tile_t [`TC_NUM_OCTETS-1:0]                     tiles;
    logic                                              result_valid;
    logic [`TC_NUM_OCTETS-1:0][3:0][3:0][`TC_XLEN-1:0] result;
    // back-pressure from the result tile buffer
    logic                                              stall;
    logic                                              meta_push;
    tc_meta_t                                          meta;

    tensor_operand_stage operand_stage (
        .clk           (clk),
        .reset         (reset),
        .operand_valid (operand_valid),
        .operand_ready (operand_ready),
        .operand       (operand),
        .stall         (stall),
        .tile_valid    (tile_valid),
        .tiles         (tiles),
        .meta_push     (meta_push),
        .meta          (meta)
    );

    tensor_dpu dpu (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .tile_valid   (tile_valid),
        .tiles        (tiles),
        .result_valid (result_valid),
        .result       (result)
    );

    tensor_writeback writeback (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result_valid),
        .result       (result),
        .stall        (stall),
        .meta_push    (meta_push),
        .meta         (meta),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

// File: tb/tensor_core_tb.sv
`timescale 1ns/1ps
`include "tensor_settings.svh"

module tensor_core_tb;
    import tensor_pkg::*;

    localparam int PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int GRP = 4 * `TC_NUM_OCTETS;
    // instruction count of all six tests for the watchdog limit
    localparam int TOTAL_INSTR = 68;

    typedef logic [`TC_XLEN-1:0] word_t;
    typedef logic [`TC_NUM_LANES-1:0][`TC_XLEN-1:0] lanes_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        operand_valid;
    logic        operand_ready;
    tc_operand_t operand;
    logic        commit_valid;
    logic        commit_ready;
    tc_commit_t  commit;

    tc_commit_t             exp_q[$];
    int                     errors = 0;
    int                     commits = 0;
    int                     failed_tests = 0;
    logic [`TC_UUID_W-1:0]  next_uuid = '0;
    // 0 always ready, 1 random, 2 blocked
    int                     ready_mode = 0;

    tensor_core uut (
        .clk           (clk),
        .reset         (reset),
        .operand_valid (operand_valid),
        .operand_ready (operand_ready),
        .operand       (operand),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    always #(PERIOD/2) clk = ~clk;

    initial begin
        commit_ready = 1'b0;
        forever begin
            @(negedge clk);
            case (ready_mode)
                0: commit_ready = 1'b1;
                1: commit_ready = 1'($urandom % 2);
                default: commit_ready = 1'b0;
            endcase
        end
    end

    task automatic compare(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // e0..e3 sit in the low lane group and e4..e7 in the high one
    function automatic word_t elem(input lanes_t regs, input int octet, input int n);
        if (n < 4) begin
            return regs[4*octet + n];
        end
        return regs[GRP + 4*octet + n - 4];
    endfunction

    // reference model with two expected commit beats per instruction
    task automatic push_expected(input tc_operand_t first, input tc_operand_t second);
        word_t      a [4][2];
        word_t      b [2][4];
        word_t      c [4][4];
        word_t      d [4][4];
        tc_commit_t beat [2];
        int         row_base [4] = '{0, 1, 4, 5};
        // first beat lanes hold D00 D10 D02 D12 low and D20 D30 D22 D32 high
        int         lane_row [4] = '{0, 1, 0, 1};
        int         lane_col [4] = '{0, 0, 2, 2};
        beat[0].meta = first.meta;
        beat[0].last = 1'b0;
        beat[1].meta = second.meta;
        beat[1].last = 1'b1;
        for (int o = 0; o < `TC_NUM_OCTETS; o++) begin
            for (int r = 0; r < 4; r++) begin
                a[r][0] = elem(first.rs1, o, row_base[r] + 2 * int'(first.step[0]));
                a[r][1] = elem(second.rs1, o, row_base[r] + 2 * int'(second.step[0]));
                b[0][r] = elem(first.rs2, o, 4 * int'(first.step[1]) + r);
                b[1][r] = elem(second.rs2, o, 4 * int'(second.step[1]) + r);
                c[r][0] = elem(first.rs3, o, row_base[r]);
                c[r][1] = elem(second.rs3, o, row_base[r]);
                c[r][2] = elem(first.rs3, o, row_base[r] + 2);
                c[r][3] = elem(second.rs3, o, row_base[r] + 2);
            end
            for (int r = 0; r < 4; r++) begin
                for (int col = 0; col < 4; col++) begin
                    d[r][col] = a[r][0] * b[0][col] + a[r][1] * b[1][col] + c[r][col];
                end
            end
            // second beat moves every lane one D column to the right
            for (int h = 0; h < 2; h++) begin
                for (int j = 0; j < 4; j++) begin
                    beat[h].data[4*o + j] = d[lane_row[j]][lane_col[j] + h];
                    beat[h].data[GRP + 4*o + j] = d[2 + lane_row[j]][lane_col[j] + h];
                end
            end
        end
        exp_q.push_back(beat[0]);
        exp_q.push_back(beat[1]);
    endtask

    function automatic tc_operand_t random_beat(input logic [`TC_UUID_W-1:0] uuid,
                                                input logic [1:0] step);
        tc_operand_t beat;
        beat.meta.uuid = uuid;
        beat.meta.wid = `TC_WID_W'($urandom);
        beat.meta.rd = `TC_RD_W'($urandom);
        beat.meta.wb = 1'($urandom);
        beat.step = step;
        for (int i = 0; i < `TC_NUM_LANES; i++) begin
            beat.rs1[i] = $urandom;
            beat.rs2[i] = $urandom;
            beat.rs3[i] = $urandom;
        end
        return beat;
    endfunction

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_beat(input tc_operand_t beat);
        operand = beat;
        operand_valid = 1'b1;
        #(PERIOD/4);
        while (!operand_ready) begin
            @(negedge clk);
            #(PERIOD/4);
        end
        @(negedge clk);
        operand_valid = 1'b0;
    endtask

    task automatic send_instr(input tc_operand_t first, input tc_operand_t second);
        push_expected(first, second);
        send_beat(first);
        send_beat(second);
    endtask

    task automatic run_random(input int count, input int gap_max);
        logic [1:0]  step;
        tc_operand_t first;
        tc_operand_t second;
        for (int i = 0; i < count; i++) begin
            step = 2'($urandom);
            first = random_beat(next_uuid, step);
            // the next beat of an instruction always moves to another step
            second = random_beat(next_uuid, step ^ 2'(1 + $urandom % 3));
            next_uuid++;
            send_instr(first, second);
            repeat ($urandom % (gap_max + 1)) @(negedge clk);
        end
    endtask

    task automatic drain;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_reset;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed, %0d errors", num, name, errors - errors_before);
        end
    endtask

    task automatic check_commit;
        tc_commit_t exp;
        if (exp_q.size() == 0) begin
            errors++;
            $display("commit beat at %0d ns arrived with nothing left to match", $time);
        end else begin
            exp = exp_q.pop_front();
            commits++;
            compare(word_t'(commit.meta.uuid), word_t'(exp.meta.uuid), "uuid");
            compare(word_t'(commit.meta.wid), word_t'(exp.meta.wid), "wid");
            compare(word_t'(commit.meta.rd), word_t'(exp.meta.rd), "rd");
            compare(word_t'(commit.meta.wb), word_t'(exp.meta.wb), "writeback enable");
            compare(word_t'(commit.last), word_t'(exp.last), "last");
            for (int i = 0; i < `TC_NUM_LANES; i++) begin
                compare(commit.data[i], exp.data[i], $sformatf("data lane %0d", i));
            end
        end
    endtask

    // sampled a quarter period after the falling edge so a transfer follows at the rising edge
    always begin
        @(negedge clk);
        #(PERIOD/4);
        if (!reset) begin
            if (!operand_ready) begin
                compare(word_t'(commit_valid), word_t'(1), "operand_ready low, no commit held");
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end
        end
    end

    initial begin
        #((TOTAL_INSTR * 20 + 2 * RESET_CYCLES) * PERIOD);
        $display("run timed out with %0d commit beats missing", exp_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        tc_operand_t first;
        tc_operand_t second;
        int          err0;
        int          wait_cycles;
        reset = 1'b1;
        operand_valid = 1'b0;
        operand = '0;
        void'($urandom(32'h5efd_5a29));
        apply_reset();

        err0 = errors;
        first = random_beat(next_uuid, 2'd0);
        second = random_beat(next_uuid, 2'd3);
        next_uuid++;
        send_instr(first, second);
        // DPU stages plus the cycle of the result tile load
        wait_cycles = 1;
        #(PERIOD/4);
        while (!commit_valid && wait_cycles < 50) begin
            @(negedge clk);
            #(PERIOD/4);
            wait_cycles++;
        end
        compare(word_t'(wait_cycles), word_t'(`TC_DPU_LATENCY + 1), "cycles to commit_valid");
        drain();
        end_test(1, "single instruction", err0);

        err0 = errors;
        for (int s = 0; s < 4; s++) begin
            first = random_beat(next_uuid, 2'(s));
            second = random_beat(next_uuid, ~2'(s));
            // small distinct A values so the selected column pair shows in D
            for (int i = 0; i < `TC_NUM_LANES; i++) begin
                first.rs1[i] = word_t'(i + 1);
                second.rs1[i] = word_t'(i + 33);
                first.rs3[i] = '0;
                second.rs3[i] = '0;
            end
            next_uuid++;
            send_instr(first, second);
        end
        drain();
        end_test(2, "step half selection", err0);

        err0 = errors;
        run_random(12, 0);
        drain();
        end_test(3, "back-to-back instructions", err0);

        err0 = errors;
        ready_mode = 1;
        run_random(40, 2);
        drain();
        end_test(4, "random back-pressure and gaps", err0);

        err0 = errors;
        run_random(8, 1);
        drain();
        ready_mode = 0;
        end_test(5, "metadata per beat", err0);

        err0 = errors;
        ready_mode = 2;
        run_random(2, 0);
        while (!commit_valid) begin
            @(negedge clk);
        end
        ready_mode = 0;
        apply_reset();
        exp_q.delete();
        #(PERIOD/4);
        compare(word_t'(commit_valid), word_t'(0), "commit_valid after reset");
        @(negedge clk);
        run_random(1, 0);
        drain();
        end_test(6, "reset mid-run", err0);

        $display("tests 6, failed %0d, commit beats %0d, errors %0d",
                 failed_tests, commits, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/tensor_pkg.sv
verilog/tensor_operand_stage.sv
verilog/tensor_dpu.sv
verilog/tensor_writeback.sv
verilog/tensor_core.sv
tb/tensor_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the tensor core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f all.f --top-module tensor_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtensor_core_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed the pass line
if grep -qx "STATUS: PASS" <<< "$output"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
